// File: Makefile
# Verilator build and run for the issue stage testbench

VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Simulation FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "failure reported, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+tests
hdl/issue_pkg.sv
hdl/issue_select.sv
hdl/issue_queue.sv
hdl/phys_regfile.sv
hdl/operand_stage.sv
hdl/issue_stage.sv
tests/issue_stage_tb.sv

// File: hdl/issue_pkg.sv
package issue_pkg;

    localparam int preg_w = 6;
    localparam int data_w = 32;
    localparam int rob_w  = 5;

    typedef logic [preg_w-1:0] preg_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [rob_w-1:0]  rob_tag_t;

    // upper bit selects the lane
    typedef enum logic [1:0] {
        op_alu1    = 2'd0,
        op_branch  = 2'd1,
        op_alu2    = 2'd2,
        op_special = 2'd3
    } op_class_t;

    typedef struct packed {
        logic      valid;
        op_class_t op_class;
        logic      rf_we;
        preg_t     dest;
        preg_t     src1;
        preg_t     src2;
        logic      src1_ready;
        logic      src2_ready;
        rob_tag_t  tag;
    } iq_entry_t;

    // alu2 and special ops go to lane 2
    function automatic logic is_lane2(op_class_t op_class);
        return op_class inside {op_alu2, op_special};
    endfunction

    // special results never wake consumers early
    function automatic preg_t wake_tag_of(logic valid, logic rf_we, op_class_t op_class,
                                          preg_t dest);
        return (valid && rf_we && op_class != op_special) ? dest : preg_t'(0);
    endfunction

endpackage

// File: hdl/issue_queue.sv
`timescale 1ns/1ps

module issue_queue import issue_pkg::*; #(
    parameter int iq_depth = 8
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      disp1_valid,
    input  op_class_t disp1_op_class,
    input  logic      disp1_rf_we,
    input  preg_t     disp1_dest,
    input  preg_t     disp1_src1,
    input  preg_t     disp1_src2,
    input  logic      disp1_src1_ready,
    input  logic      disp1_src2_ready,
    input  rob_tag_t  disp1_tag,
    input  logic      disp2_valid,
    input  op_class_t disp2_op_class,
    input  logic      disp2_rf_we,
    input  preg_t     disp2_dest,
    input  preg_t     disp2_src1,
    input  preg_t     disp2_src2,
    input  logic      disp2_src1_ready,
    input  logic      disp2_src2_ready,
    input  rob_tag_t  disp2_tag,
    output logic      disp_ready,
    input  logic      wb1_we,
    input  preg_t     wb1_dest,
    input  logic      wb2_we,
    input  preg_t     wb2_dest,
    input  preg_t     iss1_wake_tag,
    input  preg_t     iss2_wake_tag,
    output logic      sel1_valid,
    output op_class_t sel1_op_class,
    output logic      sel1_rf_we,
    output preg_t     sel1_dest,
    output preg_t     sel1_src1,
    output preg_t     sel1_src2,
    output rob_tag_t  sel1_tag,
    output logic      sel2_valid,
    output op_class_t sel2_op_class,
    output logic      sel2_rf_we,
    output preg_t     sel2_dest,
    output preg_t     sel2_src1,
    output preg_t     sel2_src2,
    output rob_tag_t  sel2_tag
);

    localparam int idx_w = $clog2(iq_depth);
    localparam int cnt_w = $clog2(iq_depth + 1);

    iq_entry_t        entries      [iq_depth];
    iq_entry_t        entries_next [iq_depth];
    // two padding slots above the top keep the compress window in range
    iq_entry_t        woken        [iq_depth + 2];
    logic [1:0]       shift        [iq_depth + 2];
    iq_entry_t        disp1_entry;
    iq_entry_t        disp2_entry;
    preg_t [5:0]      wake_tags;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] survivors;
    logic             accept1;
    logic             accept2;
    logic             lane1_valid;
    logic             lane2_valid;
    logic [idx_w-1:0] lane1_idx;
    logic [idx_w-1:0] lane2_idx;
    preg_t            lane1_wake;
    preg_t            lane2_wake;

    function automatic iq_entry_t wake_up(iq_entry_t e, preg_t [5:0] tags);
        iq_entry_t r;
        r = e;
        for (int t = 0; t < 6; t++) begin
            if (tags[t] != '0 && e.src1 == tags[t]) begin
                r.src1_ready = 1'b1;
            end
            if (tags[t] != '0 && e.src2 == tags[t]) begin
                r.src2_ready = 1'b1;
            end
        end
        return r;
    endfunction

    issue_select #(
        .iq_depth(iq_depth)
    ) issue_select_inst (
        .entries    (entries),
        .lane1_valid(lane1_valid),
        .lane1_idx  (lane1_idx),
        .lane1_wake (lane1_wake),
        .lane2_valid(lane2_valid),
        .lane2_idx  (lane2_idx),
        .lane2_wake (lane2_wake)
    );

    assign disp_ready = count <= cnt_w'(iq_depth - 2);
    assign accept1    = disp1_valid && disp_ready;
    assign accept2    = disp2_valid && disp_ready;
    assign survivors  = count - cnt_w'(lane1_valid) - cnt_w'(lane2_valid);

    assign disp1_entry = '{valid: 1'b1, op_class: disp1_op_class, rf_we: disp1_rf_we,
                           dest: disp1_dest, src1: disp1_src1, src2: disp1_src2,
                           src1_ready: disp1_src1_ready, src2_ready: disp1_src2_ready,
                           tag: disp1_tag};
    assign disp2_entry = '{valid: 1'b1, op_class: disp2_op_class, rf_we: disp2_rf_we,
                           dest: disp2_dest, src1: disp2_src1, src2: disp2_src2,
                           src1_ready: disp2_src1_ready, src2_ready: disp2_src2_ready,
                           tag: disp2_tag};

    assign wake_tags = {lane1_wake, lane2_wake, iss1_wake_tag, iss2_wake_tag,
                        wb1_we ? wb1_dest : preg_t'(0), wb2_we ? wb2_dest : preg_t'(0)};

    // wakeup, drop the picks, count how far each survivor moves down
    always_comb begin
        for (int i = 0; i < iq_depth + 2; i++) begin
            woken[i] = '0;
            shift[i] = 2'd0;
        end
        for (int i = 0; i < iq_depth; i++) begin
            woken[i] = wake_up(entries[i], wake_tags);
            if ((lane1_valid && lane1_idx == idx_w'(i))
                || (lane2_valid && lane2_idx == idx_w'(i))) begin
                woken[i].valid = 1'b0;
            end
            shift[i] = 2'(lane1_valid && lane1_idx < idx_w'(i))
                       + 2'(lane2_valid && lane2_idx < idx_w'(i));
        end
    end

    // compress by 0..2 places, then append dispatch at the tail
    always_comb begin
        for (int j = 0; j < iq_depth; j++) begin
            entries_next[j] = '0;
            for (int k = 0; k < 3; k++) begin
                if (woken[j+k].valid && shift[j+k] == 2'(k)) begin
                    entries_next[j] = woken[j+k];
                end
            end
            if (accept1 && cnt_w'(j) == survivors) begin
                entries_next[j] = wake_up(disp1_entry, wake_tags);
            end else if (accept2 && cnt_w'(j) == survivors + cnt_w'(accept1)) begin
                entries_next[j] = wake_up(disp2_entry, wake_tags);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            for (int i = 0; i < iq_depth; i++) begin
                entries[i] <= '0;
            end
        end else if (flush) begin
            count <= '0;
            for (int i = 0; i < iq_depth; i++) begin
                entries[i] <= '0;
            end
        end else begin
            count <= survivors + cnt_w'(accept1) + cnt_w'(accept2);
            for (int i = 0; i < iq_depth; i++) begin
                entries[i] <= entries_next[i];
            end
        end
    end

    assign sel1_valid    = lane1_valid;
    assign sel1_op_class = entries[lane1_idx].op_class;
    assign sel1_rf_we    = entries[lane1_idx].rf_we;
    assign sel1_dest     = entries[lane1_idx].dest;
    assign sel1_src1     = entries[lane1_idx].src1;
    assign sel1_src2     = entries[lane1_idx].src2;
    assign sel1_tag      = entries[lane1_idx].tag;

    assign sel2_valid    = lane2_valid;
    assign sel2_op_class = entries[lane2_idx].op_class;
    assign sel2_rf_we    = entries[lane2_idx].rf_we;
    assign sel2_dest     = entries[lane2_idx].dest;
    assign sel2_src1     = entries[lane2_idx].src1;
    assign sel2_src2     = entries[lane2_idx].src2;
    assign sel2_tag      = entries[lane2_idx].tag;

    assert property (@(posedge clk) disable iff (!arst_n) count <= cnt_w'(iq_depth))
        else $error("issue queue holds more than iq_depth entries");

    // occupancy never grows while dispatch is held off
    assert property (@(posedge clk) disable iff (!arst_n)
        !disp_ready && !flush |=> count <= $past(count))
        else $error("issue queue accepted an entry while disp_ready was low");

endmodule

// File: hdl/issue_select.sv
`timescale 1ns/1ps

module issue_select import issue_pkg::*; #(
    parameter int iq_depth = 8
) (
    input  iq_entry_t                   entries [iq_depth],
    output logic                        lane1_valid,
    output logic [$clog2(iq_depth)-1:0] lane1_idx,
    output preg_t                       lane1_wake,
    output logic                        lane2_valid,
    output logic [$clog2(iq_depth)-1:0] lane2_idx,
    output preg_t                       lane2_wake
);

    localparam int idx_w = $clog2(iq_depth);

    logic [iq_depth-1:0] ready1;
    logic [iq_depth-1:0] ready2;

    always_comb begin
        for (int i = 0; i < iq_depth; i++) begin
            ready1[i] = entries[i].valid && entries[i].src1_ready && entries[i].src2_ready
                        && !is_lane2(entries[i].op_class);
            ready2[i] = entries[i].valid && entries[i].src1_ready && entries[i].src2_ready
                        && is_lane2(entries[i].op_class);
        end
    end

    // index 0 is the oldest entry
    always_comb begin
        lane1_valid = 1'b0;
        lane1_idx   = '0;
        lane2_valid = 1'b0;
        lane2_idx   = '0;
        for (int i = 0; i < iq_depth; i++) begin
            if (ready1[i] && !lane1_valid) begin
                lane1_valid = 1'b1;
                lane1_idx   = idx_w'(i);
            end
            if (ready2[i] && !lane2_valid) begin
                lane2_valid = 1'b1;
                lane2_idx   = idx_w'(i);
            end
        end
    end

    // speculative wakeup from the picks
    assign lane1_wake = wake_tag_of(lane1_valid, entries[lane1_idx].rf_we,
                                    entries[lane1_idx].op_class, entries[lane1_idx].dest);
    assign lane2_wake = wake_tag_of(lane2_valid, entries[lane2_idx].rf_we,
                                    entries[lane2_idx].op_class, entries[lane2_idx].dest);

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage import issue_pkg::*; #(
    parameter int iq_depth = 8
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      disp1_valid,
    input  op_class_t disp1_op_class,
    input  logic      disp1_rf_we,
    input  preg_t     disp1_dest,
    input  preg_t     disp1_src1,
    input  preg_t     disp1_src2,
    input  logic      disp1_src1_ready,
    input  logic      disp1_src2_ready,
    input  rob_tag_t  disp1_tag,
    input  logic      disp2_valid,
    input  op_class_t disp2_op_class,
    input  logic      disp2_rf_we,
    input  preg_t     disp2_dest,
    input  preg_t     disp2_src1,
    input  preg_t     disp2_src2,
    input  logic      disp2_src1_ready,
    input  logic      disp2_src2_ready,
    input  rob_tag_t  disp2_tag,
    output logic      disp_ready,
    input  logic      wb1_we,
    input  preg_t     wb1_dest,
    input  data_t     wb1_data,
    input  logic      wb2_we,
    input  preg_t     wb2_dest,
    input  data_t     wb2_data,
    output logic      iss1_valid,
    output op_class_t iss1_op_class,
    output logic      iss1_rf_we,
    output preg_t     iss1_dest,
    output rob_tag_t  iss1_tag,
    output data_t     iss1_src1_value,
    output data_t     iss1_src2_value,
    output logic      iss2_valid,
    output op_class_t iss2_op_class,
    output logic      iss2_rf_we,
    output preg_t     iss2_dest,
    output rob_tag_t  iss2_tag,
    output data_t     iss2_src1_value,
    output data_t     iss2_src2_value
);

    logic      sel1_valid;
    op_class_t sel1_op_class;
    logic      sel1_rf_we;
    preg_t     sel1_dest;
    preg_t     sel1_src1;
    preg_t     sel1_src2;
    rob_tag_t  sel1_tag;
    logic      sel2_valid;
    op_class_t sel2_op_class;
    logic      sel2_rf_we;
    preg_t     sel2_dest;
    preg_t     sel2_src1;
    preg_t     sel2_src2;
    rob_tag_t  sel2_tag;

    preg_t     iss1_src1;
    preg_t     iss1_src2;
    preg_t     iss2_src1;
    preg_t     iss2_src2;
    data_t     iss1_src1_rdata;
    data_t     iss1_src2_rdata;
    data_t     iss2_src1_rdata;
    data_t     iss2_src2_rdata;
    preg_t     iss1_wake_tag;
    preg_t     iss2_wake_tag;

    // port names line up with the wires here
    issue_queue #(
        .iq_depth(iq_depth)
    ) issue_queue_inst (
        .*
    );

    phys_regfile phys_regfile_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb1_we  (wb1_we),
        .wb1_dest(wb1_dest),
        .wb1_data(wb1_data),
        .wb2_we  (wb2_we),
        .wb2_dest(wb2_dest),
        .wb2_data(wb2_data),
        .raddr1  (iss1_src1),
        .raddr2  (iss1_src2),
        .raddr3  (iss2_src1),
        .raddr4  (iss2_src2),
        .rdata1  (iss1_src1_rdata),
        .rdata2  (iss1_src2_rdata),
        .rdata3  (iss2_src1_rdata),
        .rdata4  (iss2_src2_rdata)
    );

    operand_stage operand_stage_inst (
        .*
    );

endmodule

// File: hdl/operand_stage.sv
`timescale 1ns/1ps

module operand_stage import issue_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      sel1_valid,
    input  op_class_t sel1_op_class,
    input  logic      sel1_rf_we,
    input  preg_t     sel1_dest,
    input  preg_t     sel1_src1,
    input  preg_t     sel1_src2,
    input  rob_tag_t  sel1_tag,
    input  logic      sel2_valid,
    input  op_class_t sel2_op_class,
    input  logic      sel2_rf_we,
    input  preg_t     sel2_dest,
    input  preg_t     sel2_src1,
    input  preg_t     sel2_src2,
    input  rob_tag_t  sel2_tag,
    input  data_t     iss1_src1_rdata,
    input  data_t     iss1_src2_rdata,
    input  data_t     iss2_src1_rdata,
    input  data_t     iss2_src2_rdata,
    input  logic      wb1_we,
    input  preg_t     wb1_dest,
    input  data_t     wb1_data,
    input  logic      wb2_we,
    input  preg_t     wb2_dest,
    input  data_t     wb2_data,
    output preg_t     iss1_src1,
    output preg_t     iss1_src2,
    output preg_t     iss2_src1,
    output preg_t     iss2_src2,
    output preg_t     iss1_wake_tag,
    output preg_t     iss2_wake_tag,
    output logic      iss1_valid,
    output op_class_t iss1_op_class,
    output logic      iss1_rf_we,
    output preg_t     iss1_dest,
    output rob_tag_t  iss1_tag,
    output data_t     iss1_src1_value,
    output data_t     iss1_src2_value,
    output logic      iss2_valid,
    output op_class_t iss2_op_class,
    output logic      iss2_rf_we,
    output preg_t     iss2_dest,
    output rob_tag_t  iss2_tag,
    output data_t     iss2_src1_value,
    output data_t     iss2_src2_value
);

    // wb1 before wb2, tag 0 is never forwarded
    function automatic data_t forward(preg_t src, data_t rdata);
        data_t value;
        value = rdata;
        if (src != '0 && wb1_we && wb1_dest == src) begin
            value = wb1_data;
        end else if (src != '0 && wb2_we && wb2_dest == src) begin
            value = wb2_data;
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss1_valid <= 1'b0;
            iss2_valid <= 1'b0;
        end else if (flush) begin
            iss1_valid <= 1'b0;
            iss2_valid <= 1'b0;
        end else begin
            iss1_valid <= sel1_valid;
            iss2_valid <= sel2_valid;
        end
    end

    // issue register payload
    always_ff @(posedge clk) begin
        iss1_op_class <= sel1_op_class;
        iss1_rf_we    <= sel1_rf_we;
        iss1_dest     <= sel1_dest;
        iss1_src1     <= sel1_src1;
        iss1_src2     <= sel1_src2;
        iss1_tag      <= sel1_tag;
        iss2_op_class <= sel2_op_class;
        iss2_rf_we    <= sel2_rf_we;
        iss2_dest     <= sel2_dest;
        iss2_src1     <= sel2_src1;
        iss2_src2     <= sel2_src2;
        iss2_tag      <= sel2_tag;
    end

    always_comb begin
        iss1_src1_value = forward(iss1_src1, iss1_src1_rdata);
        iss1_src2_value = forward(iss1_src2, iss1_src2_rdata);
        iss2_src1_value = forward(iss2_src1, iss2_src1_rdata);
        iss2_src2_value = forward(iss2_src2, iss2_src2_rdata);
    end

    assign iss1_wake_tag = wake_tag_of(iss1_valid, iss1_rf_we, iss1_op_class, iss1_dest);
    assign iss2_wake_tag = wake_tag_of(iss2_valid, iss2_rf_we, iss2_op_class, iss2_dest);

endmodule

// File: hdl/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile import issue_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  wb1_we,
    input  preg_t wb1_dest,
    input  data_t wb1_data,
    input  logic  wb2_we,
    input  preg_t wb2_dest,
    input  data_t wb2_data,
    input  preg_t raddr1,
    input  preg_t raddr2,
    input  preg_t raddr3,
    input  preg_t raddr4,
    output data_t rdata1,
    output data_t rdata2,
    output data_t rdata3,
    output data_t rdata4
);

    localparam int n_regs = 2 ** preg_w;

    data_t regs [n_regs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < n_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb2_we && wb2_dest != '0) begin
                regs[wb2_dest] <= wb2_data;
            end
            // port 1 last so it wins on the same register
            if (wb1_we && wb1_dest != '0) begin
                regs[wb1_dest] <= wb1_data;
            end
        end
    end

    // register 0 is the zero register
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];
    assign rdata4 = (raddr4 == '0) ? '0 : regs[raddr4];

endmodule

// File: tests/issue_stage_tests.svh
function automatic iq_entry_t instr(input op_class_t op_class, input logic rf_we,
                                   input preg_t dest, input preg_t src1, input logic src1_ready,
                                   input preg_t src2, input logic src2_ready, input rob_tag_t tag);
    iq_entry_t e;
    e            = '0;
    e.valid      = 1'b1;
    e.op_class   = op_class;
    e.rf_we      = rf_we;
    e.dest       = dest;
    e.src1       = src1;
    e.src2       = src2;
    e.src1_ready = src1_ready;
    e.src2_ready = src2_ready;
    e.tag        = tag;
    return e;
endfunction

// no result, both sources ready
function automatic iq_entry_t ready_op(input op_class_t op_class, input preg_t src1,
                                      input preg_t src2, input rob_tag_t tag);
    return instr(op_class, 1'b0, '0, src1, 1'b1, src2, 1'b1, tag);
endfunction

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
endtask

task automatic wait_issues(input int n1, input int n2);
    int cycles;
    cycles = 0;
    while ((lane1_q.size() < n1 || lane2_q.size() < n2) && cycles < issue_timeout) begin
        @(negedge clk);
        cycles++;
    end
    checks++;
    assert (lane1_q.size() >= n1 && lane2_q.size() >= n2) else begin
        errors++;
        $display("timed out waiting for %0d lane 1 and %0d lane 2 issues", n1, n2);
    end
endtask

task automatic check_issue(input int lane, input rob_tag_t tag, input op_class_t op_class,
                           input logic rf_we, input preg_t dest,
                           input data_t src1_value, input data_t src2_value);
    issued_t got;
    logic    present;
    string   prefix;
    prefix  = $sformatf("iss%0d", lane);
    present = (lane == 1) ? (lane1_q.size() > 0) : (lane2_q.size() > 0);
    checks++;
    assert (present) else begin
        errors++;
        $display("%s issued nothing where rob tag 0x%h was expected", prefix, tag);
    end
    if (present) begin
        if (lane == 1) begin
            got = lane1_q.pop_front();
        end else begin
            got = lane2_q.pop_front();
        end
        compare({prefix, "_tag"}, 32'(got.tag), 32'(tag));
        compare({prefix, "_op_class"}, 32'(got.op_class), 32'(op_class));
        compare({prefix, "_rf_we"}, 32'(got.rf_we), 32'(rf_we));
        compare({prefix, "_dest"}, 32'(got.dest), 32'(dest));
        compare({prefix, "_src1_value"}, got.src1_value, src1_value);
        compare({prefix, "_src2_value"}, got.src2_value, src2_value);
    end
endtask

// nothing else may issue for a while
task automatic expect_quiet(input int cycles);
    repeat (cycles) @(negedge clk);
    checks++;
    assert (lane1_q.size() == 0 && lane2_q.size() == 0) else begin
        errors++;
        $display("unexpected issue: %0d extra on lane 1 and %0d on lane 2",
                 lane1_q.size(), lane2_q.size());
    end
    lane1_q.delete();
    lane2_q.delete();
endtask

task automatic run_register_read();
    logic accepted;
    write_back(1'b1, 6'd10, next_random(), 1'b1, 6'd11, next_random());
    // the write to register 0 is dropped
    write_back(1'b1, 6'd12, next_random(), 1'b1, 6'd0, next_random());
    write_back(1'b1, 6'd13, next_random(), 1'b1, 6'd13, next_random());
    dispatch_pair(ready_op(op_alu1, 6'd10, 6'd11, 5'd1),
                  ready_op(op_alu2, 6'd12, 6'd0, 5'd2), accepted);
    dispatch_pair(ready_op(op_branch, 6'd13, 6'd0, 5'd3),
                  ready_op(op_special, 6'd11, 6'd12, 5'd4), accepted);
    wait_issues(2, 2);
    check_issue(1, 5'd1, op_alu1, 1'b0, 6'd0, ref_regs[10], ref_regs[11]);
    check_issue(2, 5'd2, op_alu2, 1'b0, 6'd0, ref_regs[12], ref_regs[0]);
    check_issue(1, 5'd3, op_branch, 1'b0, 6'd0, ref_regs[13], ref_regs[0]);
    check_issue(2, 5'd4, op_special, 1'b0, 6'd0, ref_regs[11], ref_regs[12]);
    expect_quiet(5);
endtask

task automatic run_lane_steering();
    logic  accepted;
    data_t a;
    data_t b;
    a = ref_regs[10];
    b = ref_regs[11];
    dispatch_pair(ready_op(op_alu1, 6'd10, 6'd11, 5'd8),
                  ready_op(op_alu2, 6'd10, 6'd11, 5'd9), accepted);
    dispatch_pair(ready_op(op_special, 6'd10, 6'd11, 5'd10),
                  ready_op(op_branch, 6'd10, 6'd11, 5'd11), accepted);
    dispatch_pair(ready_op(op_alu1, 6'd10, 6'd11, 5'd12),
                  ready_op(op_alu1, 6'd10, 6'd11, 5'd13), accepted);
    dispatch_pair(ready_op(op_alu2, 6'd10, 6'd11, 5'd14),
                  ready_op(op_special, 6'd10, 6'd11, 5'd15), accepted);
    wait_issues(4, 4);
    check_issue(1, 5'd8, op_alu1, 1'b0, 6'd0, a, b);
    check_issue(1, 5'd11, op_branch, 1'b0, 6'd0, a, b);
    check_issue(1, 5'd12, op_alu1, 1'b0, 6'd0, a, b);
    check_issue(1, 5'd13, op_alu1, 1'b0, 6'd0, a, b);
    check_issue(2, 5'd9, op_alu2, 1'b0, 6'd0, a, b);
    check_issue(2, 5'd10, op_special, 1'b0, 6'd0, a, b);
    check_issue(2, 5'd14, op_alu2, 1'b0, 6'd0, a, b);
    check_issue(2, 5'd15, op_special, 1'b0, 6'd0, a, b);
    expect_quiet(5);
endtask

task automatic run_writeback_wakeup();
    logic accepted;
    dispatch_pair(instr(op_alu2, 1'b0, '0, 6'd20, 1'b0, 6'd0, 1'b1, 5'd16),
                  ready_op(op_alu2, 6'd10, 6'd0, 5'd17), accepted);
    dispatch_pair(ready_op(op_special, 6'd11, 6'd0, 5'd18), '0, accepted);
    wait_issues(0, 2);
    check_issue(2, 5'd17, op_alu2, 1'b0, 6'd0, ref_regs[10], ref_regs[0]);
    check_issue(2, 5'd18, op_special, 1'b0, 6'd0, ref_regs[11], ref_regs[0]);
    expect_quiet(5);
    write_back(1'b1, 6'd20, next_random(), 1'b0, 6'd0, '0);
    wait_issues(0, 1);
    check_issue(2, 5'd16, op_alu2, 1'b0, 6'd0, ref_regs[20], ref_regs[0]);
    expect_quiet(5);
endtask

task automatic run_speculative_wakeup();
    logic accepted;
    // producer of 5 wakes its consumer on selection
    dispatch_pair(instr(op_alu1, 1'b1, 6'd5, 6'd10, 1'b1, 6'd0, 1'b1, 5'd20),
                  instr(op_alu1, 1'b0, '0, 6'd5, 1'b0, 6'd0, 1'b1, 5'd21), accepted);
    wait_issues(2, 0);
    // consumer follows its producer back to back
    checks++;
    assert (lane1_q.size() >= 2 && lane1_q[1].cycle == lane1_q[0].cycle + 1) else begin
        errors++;
        $display("consumer of tag 5 did not issue in the cycle after its producer");
    end
    check_issue(1, 5'd20, op_alu1, 1'b1, 6'd5, ref_regs[10], ref_regs[0]);
    check_issue(1, 5'd21, op_alu1, 1'b0, 6'd0, ref_regs[5], ref_regs[0]);
    expect_quiet(3);
    dispatch_pair(instr(op_special, 1'b1, 6'd7, 6'd11, 1'b1, 6'd0, 1'b1, 5'd22),
                  instr(op_alu2, 1'b0, '0, 6'd7, 1'b0, 6'd0, 1'b1, 5'd23), accepted);
    wait_issues(0, 1);
    check_issue(2, 5'd22, op_special, 1'b1, 6'd7, ref_regs[11], ref_regs[0]);
    expect_quiet(8);
    write_back(1'b1, 6'd7, next_random(), 1'b0, 6'd0, '0);
    wait_issues(0, 1);
    check_issue(2, 5'd23, op_alu2, 1'b0, 6'd0, ref_regs[7], ref_regs[0]);
    expect_quiet(3);
endtask

task automatic run_backpressure_flush();
    logic accepted;
    int   accepted_slots;
    accepted_slots = 0;
    for (int i = 0; i < iq_depth / 2 + 1; i++) begin
        dispatch_pair(instr(op_alu1, 1'b0, '0, 6'd30, 1'b0, 6'd0, 1'b1, rob_tag_t'(24 + 2 * i)),
                      instr(op_alu2, 1'b0, '0, 6'd31, 1'b0, 6'd0, 1'b1, rob_tag_t'(25 + 2 * i)),
                      accepted);
        if (accepted) begin
            accepted_slots += 2;
        end
        // ready only while two entries are free
        compare("disp_ready", 32'(disp_ready), 32'(iq_depth - accepted_slots >= 2));
    end
    compare("accepted entries", 32'(accepted_slots), 32'(iq_depth));
    // woken entries are picked in the cycle the flush lands
    write_back(1'b1, 6'd30, next_random(), 1'b1, 6'd31, next_random());
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    compare("disp_ready", 32'(disp_ready), 32'(1'b1));
    compare("iss1_valid", 32'(iss1_valid), 32'(1'b0));
    compare("iss2_valid", 32'(iss2_valid), 32'(1'b0));
    write_back(1'b1, 6'd30, next_random(), 1'b1, 6'd31, next_random());
    expect_quiet(10);
endtask

// File: tests/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb import issue_pkg::*; ();

    localparam int iq_depth      = 8;
    localparam int clk_period    = 100;
    localparam int reset_cycles  = 10;
    localparam int issue_timeout = 20;

    // cycle budget of each directed test
    localparam int register_read_cycles = 100;
    localparam int lane_steering_cycles = 100;
    localparam int wb_wakeup_cycles     = 100;
    localparam int spec_wakeup_cycles   = 100;
    localparam int flush_cycles         = 120;
    localparam int watchdog_cycles      = reset_cycles + register_read_cycles
                                          + lane_steering_cycles + wb_wakeup_cycles
                                          + spec_wakeup_cycles + flush_cycles;

    typedef struct packed {
        op_class_t   op_class;
        logic        rf_we;
        preg_t       dest;
        rob_tag_t    tag;
        data_t       src1_value;
        data_t       src2_value;
        logic [31:0] cycle;
    } issued_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        flush;
    iq_entry_t   slot1;
    iq_entry_t   slot2;
    logic        disp_ready;
    logic        wb1_we;
    preg_t       wb1_dest;
    data_t       wb1_data;
    logic        wb2_we;
    preg_t       wb2_dest;
    data_t       wb2_data;
    logic        iss1_valid;
    op_class_t   iss1_op_class;
    logic        iss1_rf_we;
    preg_t       iss1_dest;
    rob_tag_t    iss1_tag;
    data_t       iss1_src1_value;
    data_t       iss1_src2_value;
    logic        iss2_valid;
    op_class_t   iss2_op_class;
    logic        iss2_rf_we;
    preg_t       iss2_dest;
    rob_tag_t    iss2_tag;
    data_t       iss2_src1_value;
    data_t       iss2_src2_value;

    // expected register file contents
    data_t       ref_regs [2 ** preg_w];
    issued_t     lane1_q [$];
    issued_t     lane2_q [$];
    logic [31:0] rng_state;
    int          sample_cycle;
    int          checks;
    int          errors;

    issue_stage #(
        .iq_depth(iq_depth)
    ) issue_stage_inst (
        .disp1_valid     (slot1.valid),
        .disp1_op_class  (slot1.op_class),
        .disp1_rf_we     (slot1.rf_we),
        .disp1_dest      (slot1.dest),
        .disp1_src1      (slot1.src1),
        .disp1_src2      (slot1.src2),
        .disp1_src1_ready(slot1.src1_ready),
        .disp1_src2_ready(slot1.src2_ready),
        .disp1_tag       (slot1.tag),
        .disp2_valid     (slot2.valid),
        .disp2_op_class  (slot2.op_class),
        .disp2_rf_we     (slot2.rf_we),
        .disp2_dest      (slot2.dest),
        .disp2_src1      (slot2.src1),
        .disp2_src2      (slot2.src2),
        .disp2_src1_ready(slot2.src1_ready),
        .disp2_src2_ready(slot2.src2_ready),
        .disp2_tag       (slot2.tag),
        .*
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic data_t next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // one writeback cycle on both ports
    task automatic write_back(input logic we1, input preg_t dest1, input data_t data1,
                              input logic we2, input preg_t dest2, input data_t data2);
        @(negedge clk);
        wb1_we   = we1;
        wb1_dest = dest1;
        wb1_data = data1;
        wb2_we   = we2;
        wb2_dest = dest2;
        wb2_data = data2;
        // port 1 wins on a shared register, register 0 stays zero
        if (we2 && dest2 != '0) begin
            ref_regs[dest2] = data2;
        end
        if (we1 && dest1 != '0) begin
            ref_regs[dest1] = data1;
        end
        @(negedge clk);
        wb1_we = 1'b0;
        wb2_we = 1'b0;
    endtask

    // offers both slots for one edge
    task automatic dispatch_pair(input iq_entry_t a, input iq_entry_t b, output logic accepted);
        @(negedge clk);
        accepted = disp_ready;
        slot1    = a;
        slot2    = b;
        @(negedge clk);
        slot1 = '0;
        slot2 = '0;
    endtask

    `include "issue_stage_tests.svh"

    // issue outputs settle after the writeback inputs change
    always @(negedge clk) begin
        #(clk_period / 4);
        if (iss1_valid) begin
            lane1_q.push_back(issued_t'{iss1_op_class, iss1_rf_we, iss1_dest, iss1_tag,
                                        iss1_src1_value, iss1_src2_value, sample_cycle});
        end
        if (iss2_valid) begin
            lane2_q.push_back(issued_t'{iss2_op_class, iss2_rf_we, iss2_dest, iss2_tag,
                                        iss2_src1_value, iss2_src2_value, sample_cycle});
        end
        sample_cycle++;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        arst_n       = 1'b0;
        flush        = 1'b0;
        slot1        = '0;
        slot2        = '0;
        wb1_we       = 1'b0;
        wb1_dest     = '0;
        wb1_data     = '0;
        wb2_we       = 1'b0;
        wb2_dest     = '0;
        wb2_data     = '0;
        rng_state    = 32'hff46;
        sample_cycle = 0;
        checks       = 0;
        errors       = 0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        run_register_read();
        run_lane_steering();
        run_writeback_wakeup();
        run_speculative_wakeup();
        run_backpressure_flush();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
